// ==== sim.f ====
+incdir+source
source/qla_bus_pkg.sv
source/qla_axis_pkg.sv
source/board_bus_if.sv
source/reg_decode.sv
source/cur_cmd_regs.sv
source/safety_check.sv
source/dac_spi_ctrl.sv
source/reg_read_mux.sv
source/qla_board_top.sv
testbench/tb_qla_board.sv

// ==== Bender.yml ====
package:
  name: qla_board

sources:
  - include_dirs:
      - source
    files:
      - source/qla_bus_pkg.sv
      - source/qla_axis_pkg.sv
      - source/board_bus_if.sv
      - source/reg_decode.sv
      - source/cur_cmd_regs.sv
      - source/safety_check.sv
      - source/dac_spi_ctrl.sv
      - source/reg_read_mux.sv
      - source/qla_board_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_qla_board.sv

// ==== testbench/tb_qla_board.sv ====
// QLA board core testbench
// writes and reads back the axis registers, watches the DAC link and
// drives feedback over the safety limit. assertions do the checking

`timescale 1ns/10ps

`include "qla_defines.svh"

module tb_qla_board;

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    logic                   sysclk;
    logic                   arst_n;
    logic [3:0]             board_id;
    logic                   reg_wen;
    logic                   blk_wen;
    reg_addr_t              reg_waddr;
    logic [31:0]            reg_wdata;
    reg_addr_t              reg_raddr;
    logic [31:0]            reg_rdata;
    cur_array_t             cur_fb;
    logic                   dac_sclk;
    logic                   dac_mosi;
    logic                   dac_csel;
    logic [`QLA_NUM_CHAN:1] amp_disable;

    // expected state, kept from the register map rules
    logic [31:0]            lcg_state = 32'd77;
    string                  test_name = "reset";
    cur_array_t             exp_cmd;     // commands as written
    cur_array_t             snap_cmd;    // commands at start of an update
    logic [`QLA_NUM_CHAN:1] exp_dis;
    logic                   rd_chk;      // one-cycle read compare
    logic [31:0]            exp_rd;
    logic                   cnt_chk;     // one-cycle frame count compare
    int                     exp_frames;

    // DAC link monitor
    logic [`QLA_DAC_FRAME_BITS-1:0] frame_sh;
    logic [`QLA_DAC_FRAME_BITS-1:0] frame_word;
    logic [`QLA_DAC_FRAME_BITS-1:0] exp_frame;
    logic [3:0]                     frame_axis;
    logic                           frame_vld;
    int                             frame_bits;
    int                             frame_cnt;
    logic                           busy_q;
    logic                           busy_mon;

    qla_board_top i_dut (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .board_id    (board_id),
        .reg_wen     (reg_wen),
        .blk_wen     (blk_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel),
        .amp_disable (amp_disable)
    );

    always #4 sysclk = ~sysclk;    // 8 ns period

    assign busy_mon  = i_dut.dac_busy;
    assign exp_frame = {`QLA_DAC_CMD, frame_axis, snap_cmd[frame_axis]};

    // ------------------------------------------------------------------
    // helpers

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];    // upper half, better spread
    endfunction

    function automatic logic [31:0] expected_status(input logic [3:0] id,
            input logic [`QLA_NUM_CHAN:1] dis, input logic busy);
        logic [31:0] w;
        w        = 32'd0;
        w[27:24] = id;
        w[11:8]  = dis;
        w[0]     = busy;
        return w;
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic write_reg(input logic [3:0] ch, input logic [3:0] off,
                             input logic [31:0] data, input logic blk);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        blk_wen   <= blk;          // block write rides on the same strobe
        reg_waddr <= {`QLA_ADDR_MAIN, 4'h0, ch, off};
        reg_wdata <= data;
        if (ch != 4'd0 && off == `QLA_OFF_DAC_CTRL) begin
            exp_cmd[ch] <= data[15:0];
        end
        @(posedge sysclk);
        reg_wen <= 1'b0;
        blk_wen <= 1'b0;
    endtask

    task automatic check_read(input logic [3:0] ch, input logic [3:0] off,
                              input logic [31:0] exp);
        @(posedge sysclk);
        reg_raddr <= {`QLA_ADDR_MAIN, 4'h0, ch, off};
        exp_rd    <= exp;
        rd_chk    <= 1'b1;
        @(posedge sysclk);
        rd_chk    <= 1'b0;
    endtask

    task automatic check_frame_count(input int n);
        @(posedge sysclk);
        exp_frames <= n;
        cnt_chk    <= 1'b1;
        @(posedge sysclk);
        cnt_chk    <= 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        @(posedge sysclk);
        while (busy_mon !== level) begin
            if (n >= limit) begin
                $display("timeout in %s: DAC busy not %0b after %0d cycles",
                         test_name, level, limit);
                abort_run();
            end else begin
                n++;
                @(posedge sysclk);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // DAC frame monitor, one bit per sclk high phase

    always @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            frame_sh   <= '0;
            frame_word <= '0;
            frame_axis <= 4'd1;
            frame_vld  <= 1'b0;
            frame_bits <= 0;
            frame_cnt  <= 0;
            busy_q     <= 1'b0;
            for (int i = 1; i <= `QLA_NUM_CHAN; i++) begin
                snap_cmd[i] <= CUR_MIDSCALE;
            end
        end else begin
            busy_q    <= busy_mon;
            frame_vld <= 1'b0;
            if (busy_mon && !busy_q) begin
                snap_cmd <= exp_cmd;       // DUT copies as busy rises
            end
            if (!dac_csel && dac_sclk) begin   // mosi stable while sclk high
                frame_sh <= {frame_sh[`QLA_DAC_FRAME_BITS-2:0], dac_mosi};
                if (frame_bits == `QLA_DAC_FRAME_BITS - 1) begin
                    frame_word <= {frame_sh[`QLA_DAC_FRAME_BITS-2:0], dac_mosi};
                    frame_axis <= 4'(frame_cnt % `QLA_NUM_CHAN) + 4'd1;
                    frame_vld  <= 1'b1;
                    frame_cnt  <= frame_cnt + 1;
                    frame_bits <= 0;
                end else begin
                    frame_bits <= frame_bits + 1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // checks

    a_rdata: assert property (@(posedge sysclk) disable iff (!arst_n)
        rd_chk |-> reg_rdata == exp_rd)
        else begin
            $display("ERROR %s: read data expected %h, actual %h",
                     test_name, $sampled(exp_rd), $sampled(reg_rdata));
            abort_run();
        end

    a_frame: assert property (@(posedge sysclk) disable iff (!arst_n)
        frame_vld |-> frame_word == exp_frame)
        else begin
            $display("ERROR %s: DAC frame expected %h, actual %h",
                     test_name, $sampled(exp_frame), $sampled(frame_word));
            abort_run();
        end

    a_frame_cnt: assert property (@(posedge sysclk) disable iff (!arst_n)
        cnt_chk |-> frame_cnt == exp_frames)
        else begin
            $display("ERROR %s: frame count expected %0d, actual %0d",
                     test_name, $sampled(exp_frames), $sampled(frame_cnt));
            abort_run();
        end

    // idle link keeps csel high and sclk low
    a_link_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        !busy_mon |-> dac_csel && !dac_sclk)
        else begin
            $display("ERROR %s: idle DAC link expected csel 1 sclk 0, actual csel %b sclk %b",
                     test_name, $sampled(dac_csel), $sampled(dac_sclk));
            abort_run();
        end

    a_amp: assert property (@(posedge sysclk) disable iff (!arst_n)
        amp_disable == exp_dis)
        else begin
            $display("ERROR %s: amp_disable expected %b, actual %b",
                     test_name, $sampled(exp_dis), $sampled(amp_disable));
            abort_run();
        end

    // ------------------------------------------------------------------
    // stimulus

    initial begin
        int          ax;
        logic [15:0] val;
        logic [15:0] lim;
        sysclk     = 1'b0;
        arst_n     = 1'b0;
        board_id   = 4'(next_rand());
        reg_wen    = 1'b0;
        blk_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = 32'd0;
        reg_raddr  = '0;
        rd_chk     = 1'b0;
        exp_rd     = 32'd0;
        cnt_chk    = 1'b0;
        exp_frames = 0;
        exp_dis    = '0;
        for (int i = 1; i <= `QLA_NUM_CHAN; i++) begin
            cur_fb[i]  = 16'h7E01 + (next_rand() % 16'h03FF);   // inside margin
            exp_cmd[i] = CUR_MIDSCALE;
        end
        repeat (3) @(posedge sysclk);
        arst_n <= 1'b1;

        test_name = "cmd_readback";
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++) begin
            val = next_rand();
            write_reg(4'(ch), `QLA_OFF_DAC_CTRL, {next_rand(), val}, 1'b0);
            check_read(4'(ch), `QLA_OFF_DAC_CTRL, {16'd0, val});   // cycle N+2
        end

        test_name = "fb_status_read";
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++) begin
            check_read(4'(ch), `QLA_OFF_ADC_DATA, {16'd0, cur_fb[ch]});
        end
        check_read(4'd0, `QLA_OFF_STATUS, expected_status(board_id, exp_dis, 1'b0));

        test_name = "dac_frames";
        write_reg(4'd2, `QLA_OFF_DAC_CTRL, {16'd0, next_rand()}, 1'b1);
        wait_busy(1'b1, 20);
        check_read(4'd0, `QLA_OFF_STATUS, expected_status(board_id, exp_dis, 1'b1));
        wait_busy(1'b0, 400);
        check_frame_count(4);

        test_name = "dac_backpressure";
        write_reg(4'd3, `QLA_OFF_DAC_CTRL, {16'd0, next_rand()}, 1'b1);
        wait_busy(1'b1, 20);
        write_reg(4'd4, `QLA_OFF_DAC_CTRL, {16'd0, next_rand()}, 1'b1);  // mid-shift
        wait_busy(1'b0, 400);
        check_frame_count(8);
        wait_busy(1'b1, 20);               // held request goes out
        wait_busy(1'b0, 400);
        repeat (40) @(posedge sysclk);     // idle window, no third update
        check_frame_count(12);
        check_read(4'd0, `QLA_OFF_STATUS, expected_status(board_id, exp_dis, 1'b0));

        test_name = "overcurrent_trip";
        ax  = (next_rand() % `QLA_NUM_CHAN) + 1;
        val = 16'h8000 + (next_rand() & 16'h0FFF);
        write_reg(4'(ax), `QLA_OFF_DAC_CTRL, {16'd0, val}, 1'b0);
        repeat (2) @(posedge sysclk);
        lim = ((val - 16'h8000) << 1) + `QLA_SAFE_MARGIN;   // val sits above midscale
        @(posedge sysclk);
        cur_fb[ax] <= 16'h8000 - lim - 16'd1 - (next_rand() & 16'h003F);
        repeat (`QLA_SAFE_COUNT) @(posedge sysclk);
        exp_dis[ax] <= 1'b1;
        repeat (20) @(posedge sysclk);     // latch holds, others stay low
        check_read(4'd0, `QLA_OFF_STATUS, expected_status(board_id, exp_dis, 1'b0));

        test_name = "overcurrent_clear";
        @(posedge sysclk);
        cur_fb[ax] <= CUR_MIDSCALE;
        write_reg(4'd0, `QLA_OFF_STATUS, 32'(1) << (7 + ax), 1'b0);   // amp_enable
        @(posedge sysclk);
        exp_dis[ax] <= 1'b0;
        repeat (30) @(posedge sysclk);
        check_read(4'd0, `QLA_OFF_STATUS, expected_status(board_id, exp_dis, 1'b0));

        @(negedge sysclk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/qla_board_top.sv ====
// QLA motor-axis register core, top level
// decode -> command regs, safety check, DAC link -> read mux

`timescale 1ns/10ps

`include "qla_defines.svh"

module qla_board_top (
    input  logic                     sysclk,
    input  logic                     arst_n,
    input  logic [3:0]               board_id,     // rotary switch
    input  logic                     reg_wen,
    input  logic                     blk_wen,
    input  qla_bus_pkg::reg_addr_t   reg_waddr,
    input  logic [31:0]              reg_wdata,
    input  qla_bus_pkg::reg_addr_t   reg_raddr,
    output logic [31:0]              reg_rdata,
    input  qla_axis_pkg::cur_array_t cur_fb,       // measured current
    output logic                     dac_sclk,
    output logic                     dac_mosi,
    output logic                     dac_csel,
    output logic [`QLA_NUM_CHAN:1]   amp_disable
);

    import qla_axis_pkg::*;

    cur_array_t cur_cmd;
    logic       dac_busy;
    logic       data_ready;

    board_bus_if i_bus ();

    // ------------------------------------------------------------------
    // decode
    reg_decode i_decode (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .bus       (i_bus.master)
    );

    // ------------------------------------------------------------------
    // execute
    cur_cmd_regs i_cmd (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .bus        (i_bus.slave),
        .busy       (dac_busy),
        .data_ready (data_ready),
        .cur_cmd    (cur_cmd)
    );

    safety_check i_safe (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .bus         (i_bus.slave),
        .cur_cmd     (cur_cmd),
        .cur_fb      (cur_fb),
        .amp_disable (amp_disable)
    );

    dac_spi_ctrl i_dac (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .data_ready (data_ready),
        .cur_cmd    (cur_cmd),
        .busy       (dac_busy),
        .dac_sclk   (dac_sclk),
        .dac_mosi   (dac_mosi),
        .dac_csel   (dac_csel)
    );

    // ------------------------------------------------------------------
    // result
    reg_read_mux i_rmux (
        .reg_raddr   (reg_raddr),
        .board_id    (board_id),
        .busy        (dac_busy),
        .amp_disable (amp_disable),
        .cur_cmd     (cur_cmd),
        .cur_fb      (cur_fb),
        .reg_rdata   (reg_rdata)
    );

endmodule

// ==== source/reg_read_mux.sv ====
// register read mux
// picks the status word, a command or a feedback value by address

`timescale 1ns/10ps

`include "qla_defines.svh"

module reg_read_mux (
    input  qla_bus_pkg::reg_addr_t   reg_raddr,
    input  logic [3:0]               board_id,
    input  logic                     busy,
    input  logic [`QLA_NUM_CHAN:1]   amp_disable,
    input  qla_axis_pkg::cur_array_t cur_cmd,
    input  qla_axis_pkg::cur_array_t cur_fb,
    output logic [31:0]              reg_rdata
);

    logic [3:0]  chan;
    logic [31:0] status_word;

    assign chan = reg_raddr.chan;

    // 27:24 board id, 11:8 safety disables, 0 DAC busy
    assign status_word = {4'd0, board_id, 12'd0, amp_disable, 7'd0, busy};

    always_comb begin
        reg_rdata = 32'd0;                       // unmapped reads as zero
        if (reg_raddr.space == `QLA_ADDR_MAIN) begin
            if (chan == 4'd0) begin
                if (reg_raddr.offset == `QLA_OFF_STATUS) reg_rdata = status_word;
            end else if (chan <= 4'(`QLA_NUM_CHAN)) begin
                if (reg_raddr.offset == `QLA_OFF_DAC_CTRL) begin
                    reg_rdata = {16'd0, cur_cmd[chan]};
                end else if (reg_raddr.offset == `QLA_OFF_ADC_DATA) begin
                    reg_rdata = {16'd0, cur_fb[chan]};    // pot half dropped
                end
            end
        end
    end

endmodule

// ==== source/dac_spi_ctrl.sv ====
// DAC serial link
// snapshots the four commands on request and shifts one 24-bit frame
// per axis, axis 1 first, sclk at half the system clock

`timescale 1ns/10ps

`include "qla_defines.svh"

module dac_spi_ctrl (
    input  logic                     sysclk,
    input  logic                     arst_n,
    input  logic                     data_ready,
    input  qla_axis_pkg::cur_array_t cur_cmd,
    output logic                     busy,
    output logic                     dac_sclk,
    output logic                     dac_mosi,
    output logic                     dac_csel
);

    import qla_axis_pkg::*;

    localparam int BIT_W = $clog2(`QLA_DAC_FRAME_BITS);
    localparam int FRM_W = $clog2(`QLA_NUM_CHAN);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_SHIFT} dac_state_t;

    dac_state_t                     state;
    cur_array_t                     snap;        // commands being sent
    logic [`QLA_DAC_FRAME_BITS-1:0] shreg;
    logic [BIT_W-1:0]               bit_cnt;
    logic [FRM_W-1:0]               frame_cnt;
    logic [3:0]                     axis_num;

    assign axis_num = 4'(frame_cnt) + 4'd1;    // frames run axis 1..4

    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && data_ready) begin
            snap <= cur_cmd;
        end
    end

    // ------------------------------------------------------------------
    // frame FSM

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            dac_sclk  <= 1'b0;
            shreg     <= '0;
            bit_cnt   <= '0;
            frame_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    frame_cnt <= '0;
                    if (data_ready) state <= ST_LOAD;
                end
                ST_LOAD: begin                   // csel still high here
                    shreg    <= {`QLA_DAC_CMD, axis_num, snap[axis_num]};
                    bit_cnt  <= '0;
                    dac_sclk <= 1'b0;
                    state    <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    dac_sclk <= ~dac_sclk;
                    if (dac_sclk) begin          // falling edge, next bit
                        if (bit_cnt == BIT_W'(`QLA_DAC_FRAME_BITS - 1)) begin
                            frame_cnt <= frame_cnt + 1'b1;
                            state     <= (frame_cnt == FRM_W'(`QLA_NUM_CHAN - 1))
                                         ? ST_IDLE : ST_LOAD;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            shreg   <= shreg << 1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy     = (state != ST_IDLE);
    assign dac_csel = (state != ST_SHIFT);     // low only inside a frame
    assign dac_mosi = shreg[`QLA_DAC_FRAME_BITS-1];   // MSB first

    // link parks with csel high and sclk low between updates
    a_csel_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        !busy |-> dac_csel && !dac_sclk)
        else $error("DAC link not parked while idle");

endmodule

// ==== source/safety_check.sv ====
// per-axis overcurrent check
// compares feedback magnitude with twice the command plus a margin and
// latches an amplifier disable once the excess persists

`timescale 1ns/10ps

`include "qla_defines.svh"

module safety_check (
    input  logic                     sysclk,
    input  logic                     arst_n,
    board_bus_if.slave               bus,
    input  qla_axis_pkg::cur_array_t cur_cmd,
    input  qla_axis_pkg::cur_array_t cur_fb,
    output logic [`QLA_NUM_CHAN:1]   amp_disable
);

    import qla_axis_pkg::*;

    localparam int CNT_W = $clog2(`QLA_SAFE_COUNT + 1);

    // distance from midscale, 0x8000 at most
    function automatic logic [15:0] cur_mag(input cur_word_t v);
        return v[15] ? (v - CUR_MIDSCALE) : (CUR_MIDSCALE - v);
    endfunction

    for (genvar i = 1; i <= `QLA_NUM_CHAN; i++) begin : g_axis
        logic [17:0]      limit;     // 2*|cmd| + margin, no overflow
        logic             over;
        logic             clear;
        logic [CNT_W-1:0] run_cnt;   // consecutive cycles over limit
        logic             dis_q;

        assign limit = ({2'b00, cur_mag(cur_cmd[i])} << 1) + {2'b00, `QLA_SAFE_MARGIN};
        assign over  = ({2'b00, cur_mag(cur_fb[i])} > limit);
        assign clear = bus.ctrl_wen
                       && (bus.wdata.board_ctrl.pwr_enable || bus.wdata.board_ctrl.amp_enable[i]);

        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                run_cnt <= '0;
                dis_q   <= 1'b0;
            end else if (clear) begin
                run_cnt <= '0;               // host re-enable wins
                dis_q   <= 1'b0;
            end else if (over) begin
                if (run_cnt != CNT_W'(`QLA_SAFE_COUNT)) begin
                    run_cnt <= run_cnt + 1'b1;   // saturates at limit
                end
                if (run_cnt == CNT_W'(`QLA_SAFE_COUNT - 1)) begin
                    dis_q <= 1'b1;
                end
            end else begin
                run_cnt <= '0;               // run broken
            end
        end

        assign amp_disable[i] = dis_q;
    end

endmodule

// ==== source/cur_cmd_regs.sv ====
// commanded current registers
// holds one current command per axis and asks the DAC link for an
// update after a block write, waiting while the link is busy

`timescale 1ns/10ps

`include "qla_defines.svh"

module cur_cmd_regs (
    input  logic                     sysclk,
    input  logic                     arst_n,
    board_bus_if.slave               bus,
    input  logic                     busy,        // DAC link shifting
    output logic                     data_ready,  // one-cycle update request
    output qla_axis_pkg::cur_array_t cur_cmd
);

    import qla_axis_pkg::*;

    logic pending;    // block write seen, update not yet issued
    logic issue;

    // ------------------------------------------------------------------
    // command storage

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= `QLA_NUM_CHAN; i++) begin
                cur_cmd[i] <= CUR_MIDSCALE;   // zero current
            end
        end else if (bus.dac_wen) begin
            for (int i = 1; i <= `QLA_NUM_CHAN; i++) begin
                if (bus.chan == 4'(i)) begin
                    cur_cmd[i] <= bus.wdata.cur_cmd.cmd;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // update request

    // hold off while shifting, and for the cycle the request is out
    // since busy only rises one cycle later
    assign issue = pending && !busy && !data_ready;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pending    <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= issue;
            if (bus.dac_blk) begin
                pending <= 1'b1;      // new block write, remember it
            end else if (issue) begin
                pending <= 1'b0;
            end
        end
    end

    // request only goes to an idle link
    a_req_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        data_ready |-> !busy)
        else $error("DAC update requested while link busy");

endmodule

// ==== source/reg_decode.sv ====
// register write decode
// samples the host write bus once and turns space, channel and offset
// into single-cycle strobes for the DAC and the status word

`timescale 1ns/10ps

`include "qla_defines.svh"

module reg_decode (
    input  logic                   sysclk,
    input  logic                   arst_n,
    input  logic                   reg_wen,    // quadlet write strobe
    input  logic                   blk_wen,    // block write strobe
    input  qla_bus_pkg::reg_addr_t reg_waddr,
    input  logic [31:0]            reg_wdata,
    board_bus_if.master            bus
);

    logic main_space;
    logic axis_chan;
    logic addr_dac;
    logic addr_ctrl;

    // address compare, all combinational on the raw bus
    assign main_space = (reg_waddr.space == `QLA_ADDR_MAIN);
    assign axis_chan  = (reg_waddr.chan != 4'd0) && (reg_waddr.chan <= 4'(`QLA_NUM_CHAN));
    assign addr_dac   = main_space && axis_chan && (reg_waddr.offset == `QLA_OFF_DAC_CTRL);
    assign addr_ctrl  = main_space && (reg_waddr.chan == 4'd0)
                        && (reg_waddr.offset == `QLA_OFF_STATUS);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            bus.dac_wen  <= 1'b0;
            bus.dac_blk  <= 1'b0;
            bus.ctrl_wen <= 1'b0;
        end else begin
            bus.dac_wen  <= reg_wen & addr_dac;
            bus.dac_blk  <= blk_wen & addr_dac;   // same cycle as the data
            bus.ctrl_wen <= reg_wen & addr_ctrl;
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge sysclk) begin
        bus.chan  <= reg_waddr.chan;
        bus.wdata <= reg_wdata;
    end

    // the two targets live at disjoint channels
    // and a block flag only rides on its own DAC write
    a_wen_excl: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(bus.dac_wen && bus.ctrl_wen) && !(bus.dac_blk && !bus.dac_wen))
        else $error("write strobes overlap or block flag without DAC write");

endmodule

// ==== source/board_bus_if.sv ====
// decoded write bus
// strobes and payload from the decode stage to the execute stage

`timescale 1ns/10ps

interface board_bus_if;

    import qla_bus_pkg::*;

    logic       dac_wen;    // quadlet write, DAC offset of axis 1-4
    logic       dac_blk;    // block write to same, requests DAC update
    logic       ctrl_wen;   // write to channel-0 status word
    logic [3:0] chan;       // channel field of the write address
    reg_wdata_u wdata;

    modport master (
        output dac_wen, dac_blk, ctrl_wen, chan, wdata
    );

    modport slave (
        input dac_wen, dac_blk, ctrl_wen, chan, wdata
    );

endinterface

// ==== source/qla_axis_pkg.sv ====
// QLA axis types
// current words shared by the command and the feedback path

`include "qla_defines.svh"

package qla_axis_pkg;

    // 16-bit current, offset binary around midscale
    typedef logic [15:0] cur_word_t;

    localparam cur_word_t CUR_MIDSCALE = 16'h8000;  // zero current

    // one entry per axis, 1-based like the channel field
    typedef cur_word_t cur_array_t [1:`QLA_NUM_CHAN];

endpackage

// ==== source/qla_bus_pkg.sv ====
// QLA register bus types
// address fields of the host bus and the two readings of a write word

package qla_bus_pkg;

    // 16-bit register address
    typedef struct packed {
        logic [3:0] space;      // 15:12 main, hub, prom ...
        logic [3:0] rsvd;       // 11:8 unused here
        logic [3:0] chan;       // 7:4 axis, 0 = board
        logic [3:0] offset;     // 3:0 register within channel
    } reg_addr_t;

    // write to DAC offset of an axis
    typedef struct packed {
        logic [15:0] rsvd;
        logic [15:0] cmd;       // commanded current, offset binary
    } cur_cmd_view_t;

    // write to channel-0 status word
    typedef struct packed {
        logic [11:0] rsvd_hi;     // 31:20
        logic        pwr_enable;  // 19, also clears safety latch
        logic [6:0]  rsvd_mid;    // 18:12
        logic [4:1]  amp_enable;  // 11:8 axes 4..1
        logic [7:0]  rsvd_lo;     // 7:0
    } board_ctrl_view_t;

    // one write word, decoded by address
    typedef union packed {
        cur_cmd_view_t    cur_cmd;
        board_ctrl_view_t board_ctrl;
    } reg_wdata_u;

endpackage

// ==== source/qla_defines.svh ====
// QLA motor-axis register core
// board-wide constants for the register map, the DAC link and the
// overcurrent check

`ifndef QLA_DEFINES_SVH
`define QLA_DEFINES_SVH

// axes on the QLA
`define QLA_NUM_CHAN        4

// ----------------------------------------------------------------------
// register map
`define QLA_ADDR_MAIN       4'h0      // addr[15:12] of board registers

`define QLA_OFF_STATUS      4'd0      // channel 0 only
`define QLA_OFF_ADC_DATA    4'd0      // channels 1-4, measured current
`define QLA_OFF_DAC_CTRL    4'd1      // channels 1-4, commanded current

// ----------------------------------------------------------------------
// DAC link, one frame is cmd nibble + axis nibble + 16 data bits
`define QLA_DAC_FRAME_BITS  24
`define QLA_DAC_CMD         4'd3      // write-and-update command

// ----------------------------------------------------------------------
// overcurrent check
`define QLA_SAFE_MARGIN     16'h0200  // added on top of 2x command
`define QLA_SAFE_COUNT      8         // consecutive cycles over limit

`endif
